// ==== logic/dcache_pkg.sv ====
// widths, port counts and bus structs shared by every data cache stage; compile it first
`default_nettype none

package dcache_pkg;

  localparam int xlen = 32;
  localparam int num_store_ports = 3;
  localparam int num_load_ports = 2;
  localparam int num_lines = 32;

  typedef logic [xlen-1:0] addr_t;
  // index is address bits 7:3, tag is bits 15:8
  typedef logic [4:0] line_idx_t;
  typedef logic [7:0] line_tag_t;
  typedef logic [63:0] line_data_t;
  typedef logic [7:0] byte_mask_t;
  // 0 byte, 1 half, 2 word, 3 double
  typedef logic [1:0] access_size_t;

  typedef struct packed {
    logic         valid;
    addr_t        addr;
    access_size_t size;
    line_data_t   data;
  } store_req_t;

  typedef struct packed {
    logic         valid;
    addr_t        addr;
    access_size_t size;
    logic         is_signed;
  } load_req_t;

  typedef struct packed {
    logic       en;
    line_idx_t  idx;
    line_tag_t  tag;
    line_data_t data;
    byte_mask_t mask;
  } line_write_t;

  typedef struct packed {
    logic         en;
    line_idx_t    idx;
    line_tag_t    tag;
    logic [2:0]   offset;
    access_size_t size;
    logic         is_signed;
  } line_lookup_t;

  typedef struct packed {
    logic       valid;
    logic       hit;
    line_data_t data;
  } load_resp_t;

  typedef struct packed {
    logic [num_store_ports-1:0] done;
    logic [num_store_ports-1:0] retry;
  } store_resp_t;

  typedef struct packed {
    logic       en;
    line_idx_t  idx;
    line_tag_t  tag;
    line_data_t data;
    logic       dirty;
  } refill_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
  } mem_req_t;

  typedef struct packed {
    logic       valid;
    line_data_t data;
  } mem_resp_t;

  typedef struct packed {
    logic       valid;
    addr_t      addr;
    line_data_t data;
  } mem_write_t;

  // overlay the masked byte lanes of new_bytes onto old_line
  function automatic line_data_t merge_bytes(line_data_t old_line, line_data_t new_bytes,
                                             byte_mask_t mask);
    line_data_t merged;
    merged = old_line;
    for (int b = 0; b < 8; b++) begin
      if (mask[b]) begin
        merged[8*b +: 8] = new_bytes[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

// ==== logic/store_align.sv ====
// first pipeline stage of one store port, turns a byte-addressed store into a masked line write
`default_nettype none

module store_align (
  input  logic                    clock,
  input  logic                    reset,
  input  dcache_pkg::store_req_t  req,
  output dcache_pkg::line_write_t wr
);

  logic [2:0]              offset;
  dcache_pkg::byte_mask_t  mask;
  dcache_pkg::line_data_t  lane_data;
  dcache_pkg::line_write_t wr_next;

  assign offset = req.addr[2:0];

  // requests are naturally aligned, so the mask never wraps past lane 7
  always_comb begin
    case (req.size)
      2'd0: mask = 8'b0000_0001 << offset;
      2'd1: mask = 8'b0000_0011 << offset;
      2'd2: mask = 8'b0000_1111 << offset;
      default: mask = 8'b1111_1111;
    endcase
  end

  // move the low bytes of the store value up to their lanes
  assign lane_data = req.data << {offset, 3'b000};

  always_comb begin
    wr_next.en   = req.valid;
    wr_next.idx  = req.addr[7:3];
    wr_next.tag  = req.addr[15:8];
    wr_next.data = lane_data;
    wr_next.mask = mask;
  end

  always_ff @(posedge clock) begin
    wr <= wr_next;
    if (reset) begin
      wr.en <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/load_align.sv ====
// lookup and result stages of one load port, registers the lookup then extracts the loaded value
`default_nettype none

module load_align (
  input  logic                     clock,
  input  logic                     reset,
  input  dcache_pkg::load_req_t    req,
  output dcache_pkg::line_lookup_t lookup,
  input  dcache_pkg::line_data_t   line,
  input  logic                     line_hit,
  output dcache_pkg::load_resp_t   resp
);

  dcache_pkg::line_lookup_t lookup_next;
  dcache_pkg::line_data_t   shifted;
  dcache_pkg::line_data_t   extended;
  dcache_pkg::load_resp_t   resp_next;

  always_comb begin
    lookup_next.en        = req.valid;
    lookup_next.idx       = req.addr[7:3];
    lookup_next.tag       = req.addr[15:8];
    lookup_next.offset    = req.addr[2:0];
    lookup_next.size      = req.size;
    lookup_next.is_signed = req.is_signed;
  end

  always_ff @(posedge clock) begin
    lookup <= lookup_next;
    if (reset) begin
      lookup.en <= 1'b0;
    end
  end

  // bring the addressed byte lane down to bit 0
  assign shifted = line >> {lookup.offset, 3'b000};

  always_comb begin
    case (lookup.size)
      2'd0: begin
        if (lookup.is_signed) begin
          extended = {{56{shifted[7]}}, shifted[7:0]};
        end else begin
          extended = {56'b0, shifted[7:0]};
        end
      end
      2'd1: begin
        if (lookup.is_signed) begin
          extended = {{48{shifted[15]}}, shifted[15:0]};
        end else begin
          extended = {48'b0, shifted[15:0]};
        end
      end
      2'd2: begin
        if (lookup.is_signed) begin
          extended = {{32{shifted[31]}}, shifted[31:0]};
        end else begin
          extended = {32'b0, shifted[31:0]};
        end
      end
      default: extended = shifted;
    endcase
  end

  always_comb begin
    resp_next.valid = lookup.en;
    resp_next.hit   = line_hit;
    resp_next.data  = extended;
  end

  always_ff @(posedge clock) begin
    resp <= resp_next;
    if (reset) begin
      resp.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/dcache_mem.sv ====
// line storage of the direct-mapped data cache, with store merge, refill and victim writeback
`default_nettype none

module dcache_mem (
  input  logic                                                       clock,
  input  logic                                                       reset,
  input  dcache_pkg::line_write_t [dcache_pkg::num_store_ports-1:0]  wr,
  output logic [dcache_pkg::num_store_ports-1:0]                     store_hit,
  input  logic [dcache_pkg::num_store_ports-1:0]                     take_store,
  input  dcache_pkg::line_lookup_t [dcache_pkg::num_load_ports-1:0]  lookup,
  output dcache_pkg::line_data_t [dcache_pkg::num_load_ports-1:0]    line,
  output logic [dcache_pkg::num_load_ports-1:0]                      line_hit,
  input  dcache_pkg::refill_t                                        refill,
  output dcache_pkg::store_resp_t                                    store_resp,
  output dcache_pkg::mem_write_t                                     mem_write
);

  dcache_pkg::line_data_t [dcache_pkg::num_lines-1:0] data;
  dcache_pkg::line_data_t [dcache_pkg::num_lines-1:0] data_merged;
  dcache_pkg::line_data_t [dcache_pkg::num_lines-1:0] data_next;
  dcache_pkg::line_tag_t [dcache_pkg::num_lines-1:0]  tags;
  dcache_pkg::line_tag_t [dcache_pkg::num_lines-1:0]  tags_next;
  logic [dcache_pkg::num_lines-1:0]                   valid;
  logic [dcache_pkg::num_lines-1:0]                   valid_next;
  logic [dcache_pkg::num_lines-1:0]                   dirty;
  logic [dcache_pkg::num_lines-1:0]                   dirty_merged;
  logic [dcache_pkg::num_lines-1:0]                   dirty_next;
  logic [dcache_pkg::num_lines-1:0]                   waiting;
  logic [dcache_pkg::num_lines-1:0]                   waiting_next;
  dcache_pkg::mem_write_t                             victim;
  dcache_pkg::store_resp_t                            resp_next;

  // loads read the stored line, so a same-cycle store is not visible yet
  always_comb begin
    for (int p = 0; p < dcache_pkg::num_load_ports; p++) begin
      line[p]     = data[lookup[p].idx];
      line_hit[p] = valid[lookup[p].idx] && (tags[lookup[p].idx] == lookup[p].tag) &&
                    !waiting[lookup[p].idx];
    end
  end

  always_comb begin
    for (int p = 0; p < dcache_pkg::num_store_ports; p++) begin
      store_hit[p] = valid[wr[p].idx] && (tags[wr[p].idx] == wr[p].tag);
    end
  end

  always_comb begin
    for (int p = 0; p < dcache_pkg::num_store_ports; p++) begin
      resp_next.done[p]  = wr[p].en && (store_hit[p] || take_store[p]);
      resp_next.retry[p] = wr[p].en && !store_hit[p] && !take_store[p];
    end
  end

  // store hits first, higher ports land last on overlapping bytes
  always_comb begin
    data_merged  = data;
    dirty_merged = dirty;
    waiting_next = waiting;
    for (int p = 0; p < dcache_pkg::num_store_ports; p++) begin
      if (wr[p].en && store_hit[p]) begin
        data_merged[wr[p].idx]  = dcache_pkg::merge_bytes(data_merged[wr[p].idx], wr[p].data,
                                                          wr[p].mask);
        dirty_merged[wr[p].idx] = 1'b1;
      end
      if (take_store[p]) begin
        waiting_next[wr[p].idx] = 1'b1;
      end
    end
    // the refill releases its waiting line
    if (refill.en) begin
      waiting_next[refill.idx] = 1'b0;
    end
  end

  // then the refill replaces the line and may push out a dirty victim
  always_comb begin
    data_next   = data_merged;
    dirty_next  = dirty_merged;
    tags_next   = tags;
    valid_next  = valid;
    victim.valid = 1'b0;
    victim.addr  = {{(dcache_pkg::xlen-16){1'b0}}, tags[refill.idx], refill.idx, 3'b000};
    victim.data  = data_merged[refill.idx];
    if (refill.en) begin
      victim.valid            = valid[refill.idx] && dirty_merged[refill.idx] &&
                                (tags[refill.idx] != refill.tag);
      valid_next[refill.idx]   = 1'b1;
      tags_next[refill.idx]    = refill.tag;
      data_next[refill.idx]    = refill.data;
      dirty_next[refill.idx]   = refill.dirty;
    end
  end

  always_ff @(posedge clock) begin
    data       <= data_next;
    tags       <= tags_next;
    valid      <= valid_next;
    dirty      <= dirty_next;
    waiting    <= waiting_next;
    store_resp <= resp_next;
    mem_write  <= victim;
    if (reset) begin
      valid            <= '0;
      dirty            <= '0;
      waiting          <= '0;
      store_resp       <= '0;
      mem_write.valid  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/miss_handler.sv ====
// single-entry miss handler, fetches one missing line from memory and issues its refill
`default_nettype none

module miss_handler (
  input  logic                                                       clock,
  input  logic                                                       reset,
  input  dcache_pkg::line_write_t [dcache_pkg::num_store_ports-1:0]  wr,
  input  logic [dcache_pkg::num_store_ports-1:0]                     store_hit,
  output logic [dcache_pkg::num_store_ports-1:0]                     take_store,
  input  dcache_pkg::line_lookup_t [dcache_pkg::num_load_ports-1:0]  lookup,
  input  logic [dcache_pkg::num_load_ports-1:0]                      line_hit,
  output dcache_pkg::mem_req_t                                       mem_req,
  input  dcache_pkg::mem_resp_t                                      mem_resp,
  output dcache_pkg::refill_t                                        refill
);

  typedef enum logic [1:0] {idle, req, wait_mem, fill} state_t;

  state_t                 state;
  state_t                 state_next;
  logic                   take_any;
  logic                   pick_store;
  dcache_pkg::line_idx_t  pick_idx;
  dcache_pkg::line_tag_t  pick_tag;
  dcache_pkg::line_data_t pick_data;
  dcache_pkg::byte_mask_t pick_mask;
  logic                   miss_store;
  dcache_pkg::line_idx_t  miss_idx;
  dcache_pkg::line_tag_t  miss_tag;
  dcache_pkg::line_data_t miss_data;
  dcache_pkg::byte_mask_t miss_mask;
  dcache_pkg::line_data_t fill_data;

  // loads scanned first so any store miss overrides them; lowest port wins in each scan
  always_comb begin
    take_store = '0;
    take_any   = 1'b0;
    pick_store = 1'b0;
    pick_idx   = '0;
    pick_tag   = '0;
    pick_data  = '0;
    pick_mask  = '0;
    if (state == idle) begin
      for (int p = dcache_pkg::num_load_ports - 1; p >= 0; p--) begin
        if (lookup[p].en && !line_hit[p]) begin
          take_any = 1'b1;
          pick_idx = lookup[p].idx;
          pick_tag = lookup[p].tag;
        end
      end
      for (int p = dcache_pkg::num_store_ports - 1; p >= 0; p--) begin
        if (wr[p].en && !store_hit[p]) begin
          take_store    = '0;
          take_store[p] = 1'b1;
          take_any      = 1'b1;
          pick_store    = 1'b1;
          pick_idx      = wr[p].idx;
          pick_tag      = wr[p].tag;
          pick_data     = wr[p].data;
          pick_mask     = wr[p].mask;
        end
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      idle: begin
        if (take_any) begin
          state_next = req;
        end
      end
      req: state_next = wait_mem;
      wait_mem: begin
        if (mem_resp.valid) begin
          state_next = fill;
        end
      end
      default: state_next = idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (take_any) begin
      miss_store <= pick_store;
      miss_idx   <= pick_idx;
      miss_tag   <= pick_tag;
      miss_data  <= pick_data;
      miss_mask  <= pick_mask;
    end
    // a load miss carries an empty mask, so the memory line passes unchanged
    if (state == wait_mem && mem_resp.valid) begin
      fill_data <= dcache_pkg::merge_bytes(mem_resp.data, miss_data, miss_mask);
    end
    if (reset) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  assign mem_req = '{
    valid: (state == req),
    addr:  {{(dcache_pkg::xlen-16){1'b0}}, miss_tag, miss_idx, 3'b000}
  };

  assign refill = '{
    en:    (state == fill),
    idx:   miss_idx,
    tag:   miss_tag,
    data:  fill_data,
    dirty: miss_store
  };

endmodule

`default_nettype wire

// ==== logic/dcache_top.sv ====
// data cache top level, wires the store and load stages to the line storage and miss handler
`default_nettype none

module dcache_top (
  input  logic                                                     clock,
  input  logic                                                     reset,
  input  dcache_pkg::store_req_t [dcache_pkg::num_store_ports-1:0] store_req,
  output dcache_pkg::store_resp_t                                  store_resp,
  input  dcache_pkg::load_req_t [dcache_pkg::num_load_ports-1:0]   load_req,
  output dcache_pkg::load_resp_t [dcache_pkg::num_load_ports-1:0]  load_resp,
  output dcache_pkg::mem_req_t                                     mem_req,
  input  dcache_pkg::mem_resp_t                                    mem_resp,
  output dcache_pkg::mem_write_t                                   mem_write
);

  dcache_pkg::line_write_t [dcache_pkg::num_store_ports-1:0]  wr;
  logic [dcache_pkg::num_store_ports-1:0]                     store_hit;
  logic [dcache_pkg::num_store_ports-1:0]                     take_store;
  dcache_pkg::line_lookup_t [dcache_pkg::num_load_ports-1:0]  lookup;
  dcache_pkg::line_data_t [dcache_pkg::num_load_ports-1:0]    line;
  logic [dcache_pkg::num_load_ports-1:0]                      line_hit;
  dcache_pkg::refill_t                                        refill;

  for (genvar s = 0; s < dcache_pkg::num_store_ports; s++) begin : g_store
    store_align u_store_align (
      .clock (clock),
      .reset (reset),
      .req   (store_req[s]),
      .wr    (wr[s])
    );
  end

  for (genvar l = 0; l < dcache_pkg::num_load_ports; l++) begin : g_load
    load_align u_load_align (
      .clock    (clock),
      .reset    (reset),
      .req      (load_req[l]),
      .lookup   (lookup[l]),
      .line     (line[l]),
      .line_hit (line_hit[l]),
      .resp     (load_resp[l])
    );
  end

  dcache_mem u_dcache_mem (
    .clock      (clock),
    .reset      (reset),
    .wr         (wr),
    .store_hit  (store_hit),
    .take_store (take_store),
    .lookup     (lookup),
    .line       (line),
    .line_hit   (line_hit),
    .refill     (refill),
    .store_resp (store_resp),
    .mem_write  (mem_write)
  );

  miss_handler u_miss_handler (
    .clock      (clock),
    .reset      (reset),
    .wr         (wr),
    .store_hit  (store_hit),
    .take_store (take_store),
    .lookup     (lookup),
    .line_hit   (line_hit),
    .mem_req    (mem_req),
    .mem_resp   (mem_resp),
    .refill     (refill)
  );

endmodule

`default_nettype wire

// ==== dv/dcache_tb.sv ====
// random load and store testbench for the data cache with memory and reference models; run as top
`default_nettype none

module dcache_tb;

  localparam int num_cycles = 3000;
  localparam int period = 4;
  localparam int timeout = 40 * num_cycles * 5 * period;

  logic clock;
  logic reset;
  dcache_pkg::store_req_t [dcache_pkg::num_store_ports-1:0] store_req;
  dcache_pkg::store_resp_t                                  store_resp;
  dcache_pkg::load_req_t [dcache_pkg::num_load_ports-1:0]   load_req;
  dcache_pkg::load_resp_t [dcache_pkg::num_load_ports-1:0]  load_resp;
  dcache_pkg::mem_req_t                                     mem_req;
  dcache_pkg::mem_resp_t                                    mem_resp;
  dcache_pkg::mem_write_t                                   mem_write;

  logic [7:0] ref_mem [0:65535];
  logic [7:0] mem_model [0:65535];
  // one bit per line address, set by a completed store and cleared by its writeback
  logic       written [0:8191];
  // which line each index holds, as seen by a lookup
  logic       res_valid [0:31];
  logic [7:0] res_tag [0:31];

  dcache_pkg::store_req_t st1 [dcache_pkg::num_store_ports];
  dcache_pkg::store_req_t st2 [dcache_pkg::num_store_ports];
  dcache_pkg::load_req_t  ld1 [dcache_pkg::num_load_ports];
  dcache_pkg::load_req_t  ld2 [dcache_pkg::num_load_ports];
  dcache_pkg::line_data_t ld_exp [dcache_pkg::num_load_ports];
  dcache_pkg::load_req_t  retry_req [dcache_pkg::num_load_ports];
  logic                   retry_pending [dcache_pkg::num_load_ports];
  logic                   mem_busy;
  logic [15:0]            mem_addr;
  int                     mem_delay;
  int                     fill_wait;
  logic                   flight_store;
  logic                   req_expected;
  logic                   req_store;
  logic [15:0]            req_line;

  dcache_top dut (
    .clock      (clock),
    .reset      (reset),
    .store_req  (store_req),
    .store_resp (store_resp),
    .load_req   (load_req),
    .load_resp  (load_resp),
    .mem_req    (mem_req),
    .mem_resp   (mem_resp),
    .mem_write  (mem_write)
  );

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
    $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    fail_run("value mismatch");
  endtask

  // aligned address over three tags and four lines, with random bits above bit 15
  function automatic dcache_pkg::addr_t random_addr(logic [1:0] size);
    logic [7:0]  tag;
    logic [4:0]  idx;
    logic [2:0]  off;
    logic [15:0] hi;
    tag = 8'($urandom % 3);
    idx = 5'($urandom % 4);
    off = 3'($urandom % 8) & ~3'((1 << size) - 1);
    hi  = 16'($urandom);
    return {hi, tag, idx, off};
  endfunction

  function automatic logic [63:0] expected_load(logic [15:0] a, logic [1:0] size, logic sgn);
    logic [63:0] v;
    int          n;
    v = '0;
    n = 1 << size;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = ref_mem[16'(a + i)];
    end
    if (sgn && n < 8 && v[8*n-1]) begin
      for (int i = n; i < 8; i++) begin
        v[8*i +: 8] = 8'hff;
      end
    end
    return v;
  endfunction

  function automatic logic is_resident(logic [15:0] a);
    return res_valid[a[7:3]] && (res_tag[a[7:3]] == a[15:8]);
  endfunction

  // an idle handler takes the lowest missing store, else the lowest missing load
  task automatic check_stores();
    logic busy;
    logic hit;
    logic exp_done;
    busy = mem_busy || fill_wait > 0;
    for (int p = 0; p < dcache_pkg::num_store_ports; p++) begin
      if (st2[p].valid) begin
        hit      = is_resident(st2[p].addr[15:0]);
        exp_done = hit || (!busy && !req_expected);
        if (!hit && exp_done) begin
          req_expected = 1'b1;
          req_store    = 1'b1;
          req_line     = {st2[p].addr[15:3], 3'b000};
        end
        assert (store_resp.done[p] == exp_done)
          else report_mismatch($sformatf("store port %0d done", p), exp_done,
                               store_resp.done[p]);
        assert (store_resp.retry[p] == !exp_done)
          else report_mismatch($sformatf("store port %0d retry", p), !exp_done,
                               store_resp.retry[p]);
        if (store_resp.done[p]) begin
          for (int i = 0; i < (1 << st2[p].size); i++) begin
            ref_mem[16'(st2[p].addr[15:0] + i)] = st2[p].data[8*i +: 8];
          end
          written[st2[p].addr[15:3]] = 1'b1;
        end
      end else begin
        assert (!store_resp.done[p] && !store_resp.retry[p])
          else fail_run($sformatf("store port %0d answered without a request", p));
      end
    end
  endtask

  task automatic check_writeback();
    logic [63:0] exp_line;
    if (mem_write.valid) begin
      assert (mem_write.addr[2:0] == 3'b000)
        else fail_run("writeback address is not line aligned");
      assert (written[mem_write.addr[15:3]])
        else fail_run("writeback of a line that was never stored to");
      for (int i = 0; i < 8; i++) begin
        exp_line[8*i +: 8] = ref_mem[{mem_write.addr[15:3], 3'(i)}];
      end
      assert (mem_write.data == exp_line)
        else report_mismatch("writeback data", exp_line, mem_write.data);
      for (int i = 0; i < 8; i++) begin
        mem_model[{mem_write.addr[15:3], 3'(i)}] = mem_write.data[8*i +: 8];
      end
      written[mem_write.addr[15:3]] = 1'b0;
    end
  endtask

  task automatic check_loads();
    logic busy;
    logic exp_hit;
    busy = mem_busy || fill_wait > 0;
    for (int p = 0; p < dcache_pkg::num_load_ports; p++) begin
      assert (load_resp[p].valid == ld2[p].valid)
        else fail_run($sformatf("load port %0d response valid at the wrong cycle", p));
      if (ld2[p].valid) begin
        exp_hit = is_resident(ld2[p].addr[15:0]);
        // a line waiting for a store miss turns loads away
        if (busy && flight_store && ld2[p].addr[7:3] == mem_addr[7:3]) begin
          exp_hit = 1'b0;
        end
        assert (load_resp[p].hit == exp_hit)
          else report_mismatch($sformatf("load port %0d hit", p), exp_hit, load_resp[p].hit);
        if (exp_hit) begin
          assert (load_resp[p].data == ld_exp[p])
            else report_mismatch($sformatf("load port %0d data", p), ld_exp[p],
                                 load_resp[p].data);
        end else begin
          retry_pending[p] = 1'b1;
          retry_req[p]     = ld2[p];
          if (!busy && !req_expected) begin
            req_expected = 1'b1;
            req_store    = 1'b0;
            req_line     = {ld2[p].addr[15:3], 3'b000};
          end
        end
      end
    end
  endtask

  // the refilled line replaces the old one, which must have been written back if stored to
  task automatic replace_line(logic [15:0] a);
    assert (!(res_valid[a[7:3]] && written[{res_tag[a[7:3]], a[7:3]}]))
      else fail_run("a stored-to line was replaced without a writeback");
    res_valid[a[7:3]] = 1'b1;
    res_tag[a[7:3]]   = a[15:8];
  endtask

  // one outstanding read, answered 2 to 8 cycles after its request
  task automatic run_memory();
    mem_resp.valid = 1'b0;
    assert (mem_req.valid == req_expected)
      else fail_run("memory request does not follow the miss that the cache should take");
    if (mem_req.valid) begin
      assert (mem_req.addr[15:0] == req_line)
        else report_mismatch("memory request address", req_line, mem_req.addr[15:0]);
      mem_busy     = 1'b1;
      flight_store = req_store;
      mem_addr     = req_line;
      mem_delay    = 2 + int'($urandom % 7);
    end else if (mem_busy) begin
      mem_delay--;
      if (mem_delay <= 0) begin
        for (int i = 0; i < 8; i++) begin
          mem_resp.data[8*i +: 8] = mem_model[mem_addr + 16'(i)];
        end
        mem_resp.valid = 1'b1;
        mem_busy       = 1'b0;
        fill_wait      = 2;
      end
    end else if (fill_wait > 0) begin
      // lookups see the new line from the third cycle after the answer
      fill_wait--;
      if (fill_wait == 0) begin
        replace_line(mem_addr);
      end
    end
  endtask

  task automatic drive_requests(logic active);
    for (int p = 0; p < dcache_pkg::num_store_ports; p++) begin
      store_req[p].valid = active && ($urandom % 2 == 0);
      store_req[p].size  = 2'($urandom % 4);
      store_req[p].addr  = random_addr(store_req[p].size);
      store_req[p].data  = {32'($urandom), 32'($urandom)};
      st2[p] = st1[p];
      st1[p] = store_req[p];
    end
    for (int p = 0; p < dcache_pkg::num_load_ports; p++) begin
      if (active && retry_pending[p] && ($urandom % 4 != 0)) begin
        load_req[p]      = retry_req[p];
        retry_pending[p] = 1'b0;
      end else begin
        load_req[p].valid     = active && ($urandom % 2 == 0);
        load_req[p].size      = 2'($urandom % 4);
        load_req[p].addr      = random_addr(load_req[p].size);
        load_req[p].is_signed = 1'($urandom);
      end
      // the lookup reads the lines as they stand one cycle after the request
      ld2[p]    = ld1[p];
      ld_exp[p] = expected_load(ld2[p].addr[15:0], ld2[p].size, ld2[p].is_signed);
      ld1[p]    = load_req[p];
    end
  endtask

  initial begin
    timeout_watch();
  end

  task automatic timeout_watch();
    #(timeout);
    fail_run("timeout: the run did not finish in the expected time");
  endtask

  initial begin
    void'($urandom(80));
    reset        = 1'b1;
    store_req    = '0;
    load_req     = '0;
    mem_resp     = '0;
    mem_busy     = 1'b0;
    mem_addr     = '0;
    mem_delay    = 0;
    fill_wait    = 0;
    flight_store = 1'b0;
    req_expected = 1'b0;
    req_store    = 1'b0;
    req_line     = '0;
    for (int a = 0; a < 65536; a++) begin
      ref_mem[a]   = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
      mem_model[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
    end
    for (int l = 0; l < 8192; l++) begin
      written[l] = 1'b0;
    end
    for (int i = 0; i < 32; i++) begin
      res_valid[i] = 1'b0;
      res_tag[i]   = '0;
    end
    for (int p = 0; p < dcache_pkg::num_store_ports; p++) begin
      st1[p] = '0;
      st2[p] = '0;
    end
    for (int p = 0; p < dcache_pkg::num_load_ports; p++) begin
      ld1[p] = '0;
      ld2[p] = '0;
      ld_exp[p] = '0;
      retry_req[p] = '0;
      retry_pending[p] = 1'b0;
    end
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    // idle after reset before any request
    repeat (3) begin
      @(negedge clock);
      assert (!mem_req.valid && !mem_write.valid && store_resp == '0 &&
              !load_resp[0].valid && !load_resp[1].valid)
        else fail_run("outputs active after reset with no request");
    end
    for (int c = 0; c < num_cycles + 20; c++) begin
      @(negedge clock);
      req_expected = 1'b0;
      check_stores();
      check_writeback();
      check_loads();
      run_memory();
      drive_requests(c < num_cycles);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/dcache_pkg.sv
logic/store_align.sv
logic/load_align.sv
logic/dcache_mem.sv
logic/miss_handler.sv
logic/dcache_top.sv
dv/dcache_tb.sv
